// File: decode_stage.f
design/rv_decode_pkg.sv
design/opcode_classifier.sv
design/alu_op_decoder.sv
design/mem_size_decoder.sv
design/decode_stage.sv
dv/tb_clk_gen.sv
dv/tb_decode_stage.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - design/rv_decode_pkg.sv
  - design/opcode_classifier.sv
  - design/alu_op_decoder.sv
  - design/mem_size_decoder.sv
  - design/decode_stage.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_decode_stage.sv

// File: dv/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;

    import rv_decode_pkg::*;

    // RV32I major opcodes, straight from the ISA encoding
    localparam logic [6:0] OPC_OP     = 7'h33;
    localparam logic [6:0] OPC_IMM    = 7'h13;
    localparam logic [6:0] OPC_LOAD   = 7'h03;
    localparam logic [6:0] OPC_STORE  = 7'h23;
    localparam logic [6:0] OPC_BRANCH = 7'h63;
    localparam logic [6:0] OPC_JAL    = 7'h6f;
    localparam logic [6:0] OPC_JALR   = 7'h67;
    localparam logic [6:0] OPC_LUI    = 7'h37;
    localparam logic [6:0] OPC_AUIPC  = 7'h17;
    localparam logic [6:0] OPC_FENCE  = 7'h0f;
    localparam logic [6:0] OPC_SYSTEM = 7'h73;

    typedef struct packed {
        logic       valid;
        logic       illegal;
        logic       gpr_we;
        logic       mem_req;
        logic       mem_we;
        logic       branch;
        logic       jal;
        logic       jalr;
        op_a_sel_t  op_a;
        op_b_sel_t  op_b;
        alu_op_e    alu;
        ldst_size_e size;
        logic       wb;
    } exp_t;

    logic       clk;
    logic       rst_n;
    instr_t     instr_i;
    logic       instr_valid_i;
    logic       valid_o;
    op_a_sel_t  op_a_sel_o;
    op_b_sel_t  op_b_sel_o;
    alu_op_e    alu_op_o;
    logic       mem_req_o;
    logic       mem_we_o;
    ldst_size_e mem_size_o;
    logic       gpr_we_o;
    logic       wb_src_sel_o;
    logic       illegal_o;
    logic       branch_o;
    logic       jal_o;
    logic       jalr_o;

    exp_t       cur_exp;
    exp_t       exp_q;                       // Expected result, one cycle behind
    int         errors   = 0;
    int         timeouts = 0;
    int         checked  = 0;
    int         seed     = 32'h9782_5199;

    tb_clk_gen i_tb_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    decode_stage i_decode_stage (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .valid_o       (valid_o),
        .op_a_sel_o    (op_a_sel_o),
        .op_b_sel_o    (op_b_sel_o),
        .alu_op_o      (alu_op_o),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .mem_size_o    (mem_size_o),
        .gpr_we_o      (gpr_we_o),
        .wb_src_sel_o  (wb_src_sel_o),
        .illegal_o     (illegal_o),
        .branch_o      (branch_o),
        .jal_o         (jal_o),
        .jalr_o        (jalr_o)
    );

    function automatic alu_op_e base_op(input logic [2:0] f3);
        case (f3)
            3'd0:    return ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic exp_t model(input logic [31:0] ins, input logic vld);
        exp_t       e;
        logic [6:0] f7;
        logic [2:0] f3;
        logic       bad;
        logic       we;
        logic       req;
        logic       wr;
        logic       br;
        logic       jl;
        logic       jr;
        f7   = ins[31:25];
        f3   = ins[14:12];
        bad  = 1'b0;
        we   = 1'b0;
        req  = 1'b0;
        wr   = 1'b0;
        br   = 1'b0;
        jl   = 1'b0;
        jr   = 1'b0;
        e    = '0;
        e.op_a = 2'd2;                       // Zero plus constant 4 by default
        e.op_b = 3'd4;
        e.alu  = ALU_ADD;
        e.size = LDST_B;
        case (ins[6:0])
            OPC_OP: begin
                e.op_a = 2'd0;
                e.op_b = 3'd0;
                we     = 1'b1;
                if (f7 == 7'h00) e.alu = base_op(f3);
                else if (f7 == 7'h20 && f3 == 3'd0) e.alu = ALU_SUB;
                else if (f7 == 7'h20 && f3 == 3'd5) e.alu = ALU_SRA;
                else bad = 1'b1;
            end
            OPC_IMM: begin
                e.op_a = 2'd0;
                e.op_b = 3'd1;
                we     = 1'b1;
                e.alu  = base_op(f3);
                if (f3 == 3'd1 && f7 != 7'h00) bad = 1'b1;
                if (f3 == 3'd5 && f7 == 7'h20) e.alu = ALU_SRA;
                else if (f3 == 3'd5 && f7 != 7'h00) bad = 1'b1;
            end
            OPC_LOAD: begin
                e.op_a = 2'd0;
                e.op_b = 3'd1;
                req    = 1'b1;
                we     = 1'b1;
                e.wb   = 1'b1;
                if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) e.size = ldst_size_e'(f3);
                else bad = 1'b1;
            end
            OPC_STORE: begin
                e.op_a = 2'd0;
                e.op_b = 3'd3;
                req    = 1'b1;
                wr     = 1'b1;
                if (f3 <= 3'd2) e.size = ldst_size_e'(f3);
                else bad = 1'b1;
            end
            OPC_BRANCH: begin
                e.op_a = 2'd0;
                e.op_b = 3'd0;
                br     = 1'b1;
                case (f3)
                    3'd0:    e.alu = ALU_BEQ;
                    3'd1:    e.alu = ALU_BNE;
                    3'd4:    e.alu = ALU_BLT;
                    3'd5:    e.alu = ALU_BGE;
                    3'd6:    e.alu = ALU_BLTU;
                    3'd7:    e.alu = ALU_BGEU;
                    default: bad = 1'b1;
                endcase
            end
            OPC_JAL: begin
                e.op_a = 2'd1;
                we     = 1'b1;
                jl     = 1'b1;
            end
            OPC_JALR: begin
                e.op_a = 2'd1;
                we     = 1'b1;
                jr     = 1'b1;
                bad    = (f3 != 3'd0);
            end
            OPC_LUI: begin
                e.op_b = 3'd2;
                we     = 1'b1;
            end
            OPC_AUIPC: begin
                e.op_a = 2'd1;
                e.op_b = 3'd2;
                we     = 1'b1;
            end
            OPC_FENCE: ;                     // Nop, no strobes
            default: bad = 1'b1;             // SYSTEM and unknown opcodes
        endcase
        if (bad) e.alu = ALU_ADD;
        e.valid   = vld;
        e.illegal = vld & bad;
        e.gpr_we  = vld & ~bad & we;
        e.mem_req = vld & ~bad & req;
        e.mem_we  = vld & ~bad & wr;
        e.branch  = vld & ~bad & br;
        e.jal     = vld & ~bad & jl;
        e.jalr    = vld & ~bad & jr;
        return e;
    endfunction

    function automatic logic [31:0] encode(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [6:0] opc);
        return {f7, 5'd5, 5'd6, f3, 5'd7, opc};
    endfunction

    assign cur_exp = model(instr_i, instr_valid_i);

    // Data fields hold while idle, strobes drop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_q <= '0;
        end else if (instr_valid_i) begin
            exp_q <= cur_exp;
        end else begin
            exp_q.valid   <= 1'b0;
            exp_q.illegal <= 1'b0;
            exp_q.gpr_we  <= 1'b0;
            exp_q.mem_req <= 1'b0;
            exp_q.mem_we  <= 1'b0;
            exp_q.branch  <= 1'b0;
            exp_q.jal     <= 1'b0;
            exp_q.jalr    <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (valid_o) checked <= checked + 1;
    end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> {valid_o, illegal_o, gpr_we_o, mem_req_o, mem_we_o,
                    branch_o, jal_o, jalr_o} == 8'h00)
    else begin
        errors++;
        $display("Mismatch at %0t: output strobe active during reset", $time);
    end

    strobes_match: assert property (@(posedge clk) disable iff (!rst_n)
        {valid_o, illegal_o, gpr_we_o, mem_req_o, mem_we_o, branch_o, jal_o, jalr_o} ==
        {exp_q.valid, exp_q.illegal, exp_q.gpr_we, exp_q.mem_req, exp_q.mem_we,
         exp_q.branch, exp_q.jal, exp_q.jalr})
    else begin
        errors++;
        $display("Mismatch at %0t: strobes dut=%b exp=%b", $time,
                 $sampled({valid_o, illegal_o, gpr_we_o, mem_req_o, mem_we_o,
                           branch_o, jal_o, jalr_o}), $sampled(exp_q[$bits(exp_t)-1 -: 8]));
    end

    selects_match: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o |-> (op_a_sel_o == exp_q.op_a && op_b_sel_o == exp_q.op_b &&
                     wb_src_sel_o == exp_q.wb))
    else begin
        errors++;
        $display("Mismatch at %0t: operand or writeback select, exp a=%0d b=%0d wb=%b",
                 $time, $sampled(exp_q.op_a), $sampled(exp_q.op_b), $sampled(exp_q.wb));
    end

    ops_match: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o |-> (alu_op_o == exp_q.alu && mem_size_o == exp_q.size))
    else begin
        errors++;
        $display("Mismatch at %0t: alu_op dut=%0h exp=%0h size dut=%0d exp=%0d", $time,
                 $sampled(alu_op_o), $sampled(exp_q.alu),
                 $sampled(mem_size_o), $sampled(exp_q.size));
    end

    task automatic issue(input logic [31:0] ins);
        @(posedge clk);
        instr_i       <= ins;
        instr_valid_i <= 1'b1;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        instr_i       <= $random(seed);      // Junk while not valid
        instr_valid_i <= 1'b0;
    endtask

    task automatic random_stream(input int count);
        logic [31:0] ins;
        int          pick;
        for (int n = 0; n < count; n++) begin
            if (($random(seed) & 3) == 0) idle_cycle();
            ins  = $random(seed);
            pick = $random(seed) & 15;
            case (pick)
                0:  ins[6:0] = OPC_OP;
                1:  ins[6:0] = OPC_IMM;
                2:  ins[6:0] = OPC_LOAD;
                3:  ins[6:0] = OPC_STORE;
                4:  ins[6:0] = OPC_BRANCH;
                5:  ins[6:0] = OPC_JAL;
                6:  ins[6:0] = OPC_JALR;
                7:  ins[6:0] = OPC_LUI;
                8:  ins[6:0] = OPC_AUIPC;
                9:  ins[6:0] = OPC_FENCE;
                10: ins[6:0] = OPC_OP;
                11: ins[6:0] = OPC_IMM;
                default: ;                   // Raw random opcode
            endcase
            if (ins[31]) ins[31:25] = {1'b0, ins[30], 5'b0};    // Mostly legal funct7
            issue(ins);
        end
    endtask

    initial begin
        int wait_cnt;
        instr_i       = '0;
        instr_valid_i = 1'b0;

        wait_cnt = 0;
        @(posedge clk);
        while (!rst_n && wait_cnt < 20) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (!rst_n) begin
            $display("Timeout: reset was never released");
            timeouts++;
        end
        idle_cycle();

        for (int f3 = 0; f3 < 8; f3++) begin
            issue(encode(7'h00, 3'(f3), OPC_OP));
            issue(encode(7'h20, 3'(f3), OPC_OP));
            issue(encode(7'h01, 3'(f3), OPC_OP));
            issue(encode(7'h00, 3'(f3), OPC_IMM));
            issue(encode(7'h20, 3'(f3), OPC_IMM));
            issue(encode(7'h7f, 3'(f3), OPC_IMM));
            issue(encode(7'h00, 3'(f3), OPC_LOAD));
            issue(encode(7'h00, 3'(f3), OPC_STORE));
            issue(encode(7'h00, 3'(f3), OPC_BRANCH));
        end

        issue(encode(7'h12, 3'd3, OPC_JAL));
        issue(encode(7'h00, 3'd0, OPC_JALR));
        issue(encode(7'h00, 3'd3, OPC_JALR));
        issue(encode(7'h55, 3'd6, OPC_LUI));
        issue(encode(7'h2a, 3'd1, OPC_AUIPC));
        issue(encode(7'h00, 3'd0, OPC_SYSTEM));
        issue(encode(7'h00, 3'd0, 7'h7f));
        issue(encode(7'h00, 3'd0, 7'h0b));
        issue(encode(7'h00, 3'd0, OPC_FENCE));
        idle_cycle();
        issue(encode(7'h00, 3'd0, OPC_OP));

        random_stream(300);

        idle_cycle();
        idle_cycle();
        wait_cnt = 0;
        while (valid_o && wait_cnt < 10) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (valid_o) begin
            $display("Timeout: valid_o stayed high after the stream ended");
            timeouts++;
        end
        @(posedge clk);

        $display("Summary: %0d mismatches, %0d timeouts, %0d outputs checked",
                 errors, timeouts, checked);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;          // 20 ns period
    end

    initial begin
        rst_n_o = 1'b1;
        #1 rst_n_o = 1'b0;                   // Falling edge after time zero
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);                    // Release away from the edge
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire rv_decode_pkg::instr_t instr_i,
    input  wire logic                  instr_valid_i,
    output logic                       valid_o,
    output rv_decode_pkg::op_a_sel_t   op_a_sel_o,
    output rv_decode_pkg::op_b_sel_t   op_b_sel_o,
    output rv_decode_pkg::alu_op_e     alu_op_o,
    output logic                       mem_req_o,
    output logic                       mem_we_o,
    output rv_decode_pkg::ldst_size_e  mem_size_o,
    output logic                       gpr_we_o,
    output logic                       wb_src_sel_o,
    output logic                       illegal_o,
    output logic                       branch_o,
    output logic                       jal_o,
    output logic                       jalr_o
);

    import rv_decode_pkg::*;

    instr_class_e cls;
    op_a_sel_t    op_a_sel;
    op_b_sel_t    op_b_sel;
    alu_op_e      alu_op;
    ldst_size_e   mem_size;
    logic         wb_src_sel;
    logic         gpr_we, mem_req, mem_we;
    logic         branch, jal, jalr;
    logic         cls_illegal, alu_illegal, mem_illegal;
    logic         illegal;
    logic         fire;                        // Valid and legal

    opcode_classifier i_opcode_classifier (
        .opcode_i     (instr_i[6:0]),
        .funct3_i     (instr_i[14:12]),
        .cls_o        (cls),
        .op_a_sel_o   (op_a_sel),
        .op_b_sel_o   (op_b_sel),
        .wb_src_sel_o (wb_src_sel),
        .gpr_we_o     (gpr_we),
        .mem_req_o    (mem_req),
        .mem_we_o     (mem_we),
        .branch_o     (branch),
        .jal_o        (jal),
        .jalr_o       (jalr),
        .illegal_o    (cls_illegal)
    );

    alu_op_decoder i_alu_op_decoder (
        .cls_i     (cls),
        .funct3_i  (instr_i[14:12]),
        .funct7_i  (instr_i[31:25]),
        .alu_op_o  (alu_op),
        .illegal_o (alu_illegal)
    );

    mem_size_decoder i_mem_size_decoder (
        .cls_i     (cls),
        .funct3_i  (instr_i[14:12]),
        .size_o    (mem_size),
        .illegal_o (mem_illegal)
    );

    assign illegal = cls_illegal | alu_illegal | mem_illegal;
    assign fire    = instr_valid_i & ~illegal;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o      <= 1'b0;
            illegal_o    <= 1'b0;
            gpr_we_o     <= 1'b0;
            mem_req_o    <= 1'b0;
            mem_we_o     <= 1'b0;
            branch_o     <= 1'b0;
            jal_o        <= 1'b0;
            jalr_o       <= 1'b0;
            op_a_sel_o   <= OPA_RS1;
            op_b_sel_o   <= OPB_RS2;
            alu_op_o     <= ALU_ADD;
            mem_size_o   <= LDST_B;
            wb_src_sel_o <= 1'b0;
        end else begin
            valid_o   <= instr_valid_i;
            illegal_o <= instr_valid_i & illegal;
            gpr_we_o  <= fire & gpr_we;        // No side effects when illegal
            mem_req_o <= fire & mem_req;
            mem_we_o  <= fire & mem_we;
            branch_o  <= fire & branch;
            jal_o     <= fire & jal;
            jalr_o    <= fire & jalr;
            if (instr_valid_i) begin
                op_a_sel_o   <= op_a_sel;
                op_b_sel_o   <= op_b_sel;
                alu_op_o     <= alu_op;
                mem_size_o   <= mem_size;
                wb_src_sel_o <= wb_src_sel;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mem_size_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module mem_size_decoder (
    input  rv_decode_pkg::instr_class_e  cls_i,
    input  wire logic [2:0]              funct3_i,
    output rv_decode_pkg::ldst_size_e    size_o,
    output logic                         illegal_o
);

    import rv_decode_pkg::*;

    always_comb begin
        size_o    = LDST_B;
        illegal_o = 1'b0;

        case (cls_i)
            CLS_LOAD: begin
                case (funct3_i)
                    3'd0:    size_o = LDST_B;
                    3'd1:    size_o = LDST_H;
                    3'd2:    size_o = LDST_W;
                    3'd4:    size_o = LDST_BU;
                    3'd5:    size_o = LDST_HU;
                    default: illegal_o = 1'b1;
                endcase
            end
            CLS_STORE: begin
                case (funct3_i)                  // No unsigned stores
                    3'd0:    size_o = LDST_B;
                    3'd1:    size_o = LDST_H;
                    3'd2:    size_o = LDST_W;
                    default: illegal_o = 1'b1;
                endcase
            end
            default: size_o = LDST_B;
        endcase
    end

endmodule

`default_nettype wire

// File: design/alu_op_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module alu_op_decoder (
    input  rv_decode_pkg::instr_class_e  cls_i,
    input  wire logic [2:0]              funct3_i,
    input  wire logic [6:0]              funct7_i,
    output rv_decode_pkg::alu_op_e       alu_op_o,
    output logic                         illegal_o
);

    import rv_decode_pkg::*;

    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;    // SUB and SRA

    always_comb begin
        alu_op_o  = ALU_ADD;
        illegal_o = 1'b0;

        case (cls_i)
            CLS_ALU_R: begin
                case ({funct7_i, funct3_i})
                    {F7_BASE, 3'd0}: alu_op_o = ALU_ADD;
                    {F7_ALT,  3'd0}: alu_op_o = ALU_SUB;
                    {F7_BASE, 3'd4}: alu_op_o = ALU_XOR;
                    {F7_BASE, 3'd6}: alu_op_o = ALU_OR;
                    {F7_BASE, 3'd7}: alu_op_o = ALU_AND;
                    {F7_BASE, 3'd1}: alu_op_o = ALU_SLL;
                    {F7_BASE, 3'd5}: alu_op_o = ALU_SRL;
                    {F7_ALT,  3'd5}: alu_op_o = ALU_SRA;
                    {F7_BASE, 3'd2}: alu_op_o = ALU_SLT;
                    {F7_BASE, 3'd3}: alu_op_o = ALU_SLTU;
                    default:         illegal_o = 1'b1;
                endcase
            end
            CLS_ALU_I: begin
                case (funct3_i)
                    3'd0: alu_op_o = ALU_ADD;
                    3'd2: alu_op_o = ALU_SLT;
                    3'd3: alu_op_o = ALU_SLTU;
                    3'd4: alu_op_o = ALU_XOR;
                    3'd6: alu_op_o = ALU_OR;
                    3'd7: alu_op_o = ALU_AND;
                    3'd1: begin
                        if (funct7_i == F7_BASE) alu_op_o = ALU_SLL;
                        else illegal_o = 1'b1;
                    end
                    3'd5: begin
                        if (funct7_i == F7_BASE) alu_op_o = ALU_SRL;
                        else if (funct7_i == F7_ALT) alu_op_o = ALU_SRA;
                        else illegal_o = 1'b1;
                    end
                endcase
            end
            CLS_BRANCH: begin
                case (funct3_i)
                    3'd0:    alu_op_o = ALU_BEQ;
                    3'd1:    alu_op_o = ALU_BNE;
                    3'd4:    alu_op_o = ALU_BLT;
                    3'd5:    alu_op_o = ALU_BGE;
                    3'd6:    alu_op_o = ALU_BLTU;
                    3'd7:    alu_op_o = ALU_BGEU;
                    default: illegal_o = 1'b1;   // funct3 2 and 3
                endcase
            end
            default: alu_op_o = ALU_ADD;         // Address and link adds
        endcase
    end

endmodule

`default_nettype wire

// File: design/opcode_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module opcode_classifier (
    input  wire logic [6:0]                opcode_i,
    input  wire logic [2:0]                funct3_i,
    output rv_decode_pkg::instr_class_e    cls_o,
    output rv_decode_pkg::op_a_sel_t       op_a_sel_o,
    output rv_decode_pkg::op_b_sel_t       op_b_sel_o,
    output logic                           wb_src_sel_o,
    output logic                           gpr_we_o,
    output logic                           mem_req_o,
    output logic                           mem_we_o,
    output logic                           branch_o,
    output logic                           jal_o,
    output logic                           jalr_o,
    output logic                           illegal_o
);

    import rv_decode_pkg::*;

    always_comb begin
        cls_o        = CLS_OTHER;
        op_a_sel_o   = OPA_ZERO;
        op_b_sel_o   = OPB_INCR;
        wb_src_sel_o = 1'b0;
        gpr_we_o     = 1'b0;
        mem_req_o    = 1'b0;
        mem_we_o     = 1'b0;
        branch_o     = 1'b0;
        jal_o        = 1'b0;
        jalr_o       = 1'b0;
        illegal_o    = 1'b0;

        case (opcode_i)
            OP: begin
                cls_o      = CLS_ALU_R;
                op_a_sel_o = OPA_RS1;
                op_b_sel_o = OPB_RS2;
                gpr_we_o   = 1'b1;
            end
            OP_IMM: begin
                cls_o      = CLS_ALU_I;
                op_a_sel_o = OPA_RS1;
                op_b_sel_o = OPB_IMM_I;
                gpr_we_o   = 1'b1;
            end
            LOAD: begin
                cls_o        = CLS_LOAD;
                op_a_sel_o   = OPA_RS1;
                op_b_sel_o   = OPB_IMM_I;
                mem_req_o    = 1'b1;
                wb_src_sel_o = 1'b1;         // Writeback from memory
                gpr_we_o     = 1'b1;
            end
            STORE: begin
                cls_o      = CLS_STORE;
                op_a_sel_o = OPA_RS1;
                op_b_sel_o = OPB_IMM_S;
                mem_req_o  = 1'b1;
                mem_we_o   = 1'b1;
            end
            BRANCH: begin
                cls_o      = CLS_BRANCH;
                op_a_sel_o = OPA_RS1;
                op_b_sel_o = OPB_RS2;
                branch_o   = 1'b1;
            end
            JAL: begin
                op_a_sel_o = OPA_PC;         // Link address PC + 4
                gpr_we_o   = 1'b1;
                jal_o      = 1'b1;
            end
            JALR: begin
                op_a_sel_o = OPA_PC;
                gpr_we_o   = 1'b1;
                jalr_o     = 1'b1;
                illegal_o  = (funct3_i != 3'd0);
            end
            LUI: begin
                op_b_sel_o = OPB_IMM_U;      // 0 + imm
                gpr_we_o   = 1'b1;
            end
            AUIPC: begin
                op_a_sel_o = OPA_PC;
                op_b_sel_o = OPB_IMM_U;
                gpr_we_o   = 1'b1;
            end
            MISC_MEM: begin
                cls_o = CLS_OTHER;           // FENCE acts as a nop
            end
            default: begin
                cls_o     = CLS_ILLEGAL;
                illegal_o = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

    localparam int INSTR_W = 32;

    typedef logic [INSTR_W-1:0] instr_t;

    // RV32I major opcodes kept by this decoder
    typedef enum logic [6:0] {
        OP       = 7'b0110011,
        OP_IMM   = 7'b0010011,
        LOAD     = 7'b0000011,
        STORE    = 7'b0100011,
        BRANCH   = 7'b1100011,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        LUI      = 7'b0110111,
        AUIPC    = 7'b0010111,
        MISC_MEM = 7'b0001111
    } opcode_e;

    typedef enum logic [2:0] {
        CLS_ALU_R,
        CLS_ALU_I,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_OTHER,
        CLS_ILLEGAL
    } instr_class_e;

    // Compares live in the upper half, low bits follow branch funct3
    typedef enum logic [4:0] {
        ALU_ADD  = 5'b00000,
        ALU_SUB  = 5'b01000,
        ALU_XOR  = 5'b00100,
        ALU_OR   = 5'b00110,
        ALU_AND  = 5'b00111,
        ALU_SLL  = 5'b00001,
        ALU_SRL  = 5'b00101,
        ALU_SRA  = 5'b01101,
        ALU_SLT  = 5'b00010,
        ALU_SLTU = 5'b00011,
        ALU_BEQ  = 5'b11000,
        ALU_BNE  = 5'b11001,
        ALU_BLT  = 5'b11100,
        ALU_BGE  = 5'b11101,
        ALU_BLTU = 5'b11110,
        ALU_BGEU = 5'b11111
    } alu_op_e;

    typedef enum logic [2:0] {
        LDST_B  = 3'd0,
        LDST_H  = 3'd1,
        LDST_W  = 3'd2,
        LDST_BU = 3'd4,
        LDST_HU = 3'd5
    } ldst_size_e;

    typedef logic [1:0] op_a_sel_t;
    typedef logic [2:0] op_b_sel_t;

    localparam op_a_sel_t OPA_RS1  = 2'd0;
    localparam op_a_sel_t OPA_PC   = 2'd1;
    localparam op_a_sel_t OPA_ZERO = 2'd2;

    localparam op_b_sel_t OPB_RS2   = 3'd0;
    localparam op_b_sel_t OPB_IMM_I = 3'd1;
    localparam op_b_sel_t OPB_IMM_U = 3'd2;
    localparam op_b_sel_t OPB_IMM_S = 3'd3;
    localparam op_b_sel_t OPB_INCR  = 3'd4;

endpackage

`default_nettype wire
